/* hdl/aluPkg.sv */
package aluPkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths and saturation limits
  ////////////////////////////////////////////////////////////////////////////
  localparam int wordW = 16;  // Datapath width
  localparam int nibW  = 4;   // One lane / one CLA group
  localparam int nibN  = 4;   // Nibbles per word

  localparam logic [wordW-1:0] wordSatPos = 16'h7FFF;  // Largest signed word
  localparam logic [wordW-1:0] wordSatNeg = 16'h8000;  // Smallest signed word
  localparam logic [nibW-1:0]  nibSatPos  = 4'h7;      // Largest signed lane
  localparam logic [nibW-1:0]  nibSatNeg  = 4'h8;      // Smallest signed lane

  ////////////////////////////////////////////////////////////////////////////
  // Command and response types
  ////////////////////////////////////////////////////////////////////////////
  // Bit 0 picks subtract, bit 1 picks nibble mode
  typedef enum logic [1:0] {
    opAdd    = 2'd0,
    opSub    = 2'd1,
    opPaddsb = 2'd2,
    opPsubsb = 2'd3
  } aluOpT;

  typedef struct packed {
    aluOpT            op;
    logic [wordW-1:0] a;
    logic [wordW-1:0] b;  // Subtrahend for the sub ops
  } aluCmdT;

  typedef struct packed {
    logic zero;  // Result is all zeros
    logic neg;   // Sign of the result
    logic ovfl;  // Some saturation took place
  } aluFlagsT;

  typedef struct packed {
    logic [wordW-1:0] result;
    aluFlagsT         flags;
  } aluRespT;

endpackage

/* hdl/cla4.sv */
`timescale 1ns/10ps
`default_nettype none

module cla4 (
  input  logic [3:0] a,
  input  logic [3:0] b,
  input  logic       cin,      // From parent, 1 on the low nibble of a subtract
  input  logic       sub,      // Invert b
  output logic [3:0] sum,
  output logic       posOvfl,  // Two positives gave a negative
  output logic       negOvfl,  // Two negatives gave a positive
  output logic       pGroup,   // Group propagate for the lookahead unit
  output logic       gGroup    // Group generate for the lookahead unit
);

  logic [3:0] bOp;  // b or its ones complement
  logic [3:0] p;    // Bit propagate
  logic [3:0] g;    // Bit generate
  logic [2:0] c;    // Carries into bits 1 to 3

  assign bOp = sub ? ~b : b;
  assign p   = a | bOp;
  assign g   = a & bOp;

  // Lookahead carries, all from cin
  assign c[0] = g[0] | (p[0] & cin);
  assign c[1] = g[1] | (p[1] & g[0]) | (p[1] & p[0] & cin);
  assign c[2] = g[2] | (p[2] & g[1]) | (p[2] & p[1] & g[0])
              | (p[2] & p[1] & p[0] & cin);

  assign sum = a ^ bOp ^ {c, cin};  // Carry vector lines up with bits 3..0

  // Signed overflow from the operand and sum signs
  assign posOvfl = ~a[3] & ~bOp[3] & sum[3];
  assign negOvfl = a[3] & bOp[3] & ~sum[3];

  ////////////////////////////////////////////////////////////////////////////
  // Group terms, independent of cin
  ////////////////////////////////////////////////////////////////////////////
  assign pGroup = &p;
  assign gGroup = g[3] | (p[3] & g[2]) | (p[3] & p[2] & g[1])
                | (p[3] & p[2] & p[1] & g[0]);  // Carry out when cin is 0

endmodule

`default_nettype wire

/* hdl/wordAdder.sv */
`timescale 1ns/10ps
`default_nettype none

module wordAdder (
  input  logic [15:0] a,
  input  logic [15:0] b,
  input  logic        sub,   // Also the word carry-in
  output logic [15:0] res,   // Saturated sum
  output logic        ovfl,
  output logic        neg
);

  import aluPkg::*;

  logic [nibN-1:0]  cIn;    // Carry into each nibble
  logic [nibN-1:0]  pGrp;
  logic [nibN-1:0]  gGrp;
  logic [nibN-1:0]  posOv;
  logic [nibN-1:0]  negOv;
  logic [wordW-1:0] sum;    // Raw wrap-around sum

  ////////////////////////////////////////////////////////////////////////////
  // Second level lookahead across the nibbles
  ////////////////////////////////////////////////////////////////////////////
  assign cIn[0] = sub;
  assign cIn[1] = gGrp[0] | (pGrp[0] & sub);
  assign cIn[2] = gGrp[1] | (pGrp[1] & gGrp[0]) | (pGrp[1] & pGrp[0] & sub);
  assign cIn[3] = gGrp[2] | (pGrp[2] & gGrp[1]) | (pGrp[2] & pGrp[1] & gGrp[0])
                | (pGrp[2] & pGrp[1] & pGrp[0] & sub);

  for (genvar i = 0; i < nibN; i++) begin : nibSlice
    cla4 cla4Inst (
      .a       (a[i*nibW +: nibW]),
      .b       (b[i*nibW +: nibW]),
      .cin     (cIn[i]),
      .sub     (sub),
      .sum     (sum[i*nibW +: nibW]),
      .posOvfl (posOv[i]),
      .negOvfl (negOv[i]),
      .pGroup  (pGrp[i]),
      .gGroup  (gGrp[i])
    );
  end

  // Only the top nibble's overflow is the word overflow
  assign ovfl = posOv[nibN-1] | negOv[nibN-1];

  always_comb begin
    if (posOv[nibN-1])
      res = wordSatPos;  // Clamp high
    else if (negOv[nibN-1])
      res = wordSatNeg;  // Clamp low
    else
      res = sum;
  end

  assign neg = res[wordW-1];

endmodule

`default_nettype wire

/* hdl/nibbleAdder.sv */
`timescale 1ns/10ps
`default_nettype none

module nibbleAdder (
  input  logic [15:0] a,
  input  logic [15:0] b,
  input  logic        sub,
  output logic [15:0] res,   // Four saturated lanes
  output logic        ovfl   // Any lane clamped
);

  import aluPkg::*;

  logic [wordW-1:0] sum;     // Raw lane sums
  logic [nibN-1:0]  posOv;
  logic [nibN-1:0]  negOv;

  ////////////////////////////////////////////////////////////////////////////
  // Independent lanes, no carry crosses a nibble boundary
  ////////////////////////////////////////////////////////////////////////////
  for (genvar i = 0; i < nibN; i++) begin : lane
    cla4 cla4Inst (
      .a       (a[i*nibW +: nibW]),
      .b       (b[i*nibW +: nibW]),
      .cin     (sub),                // Each lane does its own two's complement
      .sum     (sum[i*nibW +: nibW]),
      .sub     (sub),
      .posOvfl (posOv[i]),
      .negOvfl (negOv[i]),
      .pGroup  (),                   // Lookahead terms not needed per lane
      .gGroup  ()
    );

    // Per-lane clamp
    always_comb begin
      if (posOv[i])
        res[i*nibW +: nibW] = nibSatPos;
      else if (negOv[i])
        res[i*nibW +: nibW] = nibSatNeg;
      else
        res[i*nibW +: nibW] = sum[i*nibW +: nibW];
    end
  end

  assign ovfl = |(posOv | negOv);

endmodule

`default_nettype wire

/* hdl/resultMerge.sv */
`timescale 1ns/10ps
`default_nettype none

module resultMerge (
  input  logic            nibMode,   // Op bit 1
  input  logic [15:0]     wordRes,
  input  logic [15:0]     nibRes,
  input  logic            wordOvfl,
  input  logic            nibOvfl,
  output aluPkg::aluRespT resp
);

  import aluPkg::*;

  logic [wordW-1:0] chosen;     // Result of the selected path
  logic             chosenOvfl;

  ////////////////////////////////////////////////////////////////////////////
  // Path select
  ////////////////////////////////////////////////////////////////////////////
  assign chosen     = nibMode ? nibRes : wordRes;
  assign chosenOvfl = nibMode ? nibOvfl : wordOvfl;

  // Flags come from the saturated value, not the raw sum
  always_comb begin
    resp.result     = chosen;
    resp.flags.zero = (chosen == '0);
    resp.flags.neg  = chosen[wordW-1];  // Sign bit of the word
    resp.flags.ovfl = chosenOvfl;
  end

endmodule

`default_nettype wire

/* hdl/reqAckPort.sv */
`timescale 1ns/10ps
`default_nettype none

module reqAckPort (
  input  logic            clk,
  input  logic            rst,
  input  logic            req,
  input  aluPkg::aluCmdT  cmd,
  input  aluPkg::aluRespT respNext,  // Combinational result of cmdReg
  output logic            ack,
  output aluPkg::aluCmdT  cmdReg,    // Held command for the datapath
  output aluPkg::aluRespT resp
);

  typedef enum logic [1:0] {
    stIdle,     // Waiting for req
    stCompute,  // Command captured, datapath settling
    stHold      // ack up, waiting for req to drop
  } portStateT;

  portStateT state;

  ////////////////////////////////////////////////////////////////////////////
  // Handshake FSM
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= stIdle;
      ack   <= 1'b0;
      resp  <= '0;
    end else begin
      case (state)
        stIdle:
          if (req) state <= stCompute;  // cmd taken in the payload block
        stCompute: begin
          resp  <= respNext;
          ack   <= 1'b1;
          state <= stHold;
        end
        stHold:
          if (!req) begin
            ack   <= 1'b0;              // Phase four, back to idle
            state <= stIdle;
          end
        default: state <= stIdle;
      endcase
    end
  end

  // Command register, loads only when a new request is accepted
  always_ff @(posedge clk) begin
    if (state == stIdle && req)
      cmdReg <= cmd;
  end

  // ack rises only in answer to a request seen on the previous edge
  ackAfterReq: assert property (@(posedge clk) disable iff (rst)
    $rose(ack) |-> $past(req));

  // Response frozen for the whole ack phase
  respHeld: assert property (@(posedge clk) disable iff (rst)
    ack && $past(ack) |-> $stable(resp));

endmodule

`default_nettype wire

/* hdl/aluTop.sv */
`timescale 1ns/10ps
`default_nettype none

module aluTop (
  input  logic            clk,
  input  logic            rst,
  input  logic            req,
  input  aluPkg::aluCmdT  cmd,
  output logic            ack,
  output aluPkg::aluRespT resp
);

  import aluPkg::*;

  aluCmdT           cmdReg;
  aluRespT          respNext;
  logic [wordW-1:0] wordRes;
  logic             wordOvfl;
  logic [wordW-1:0] nibRes;
  logic             nibOvfl;

  ////////////////////////////////////////////////////////////////////////////
  // Port and datapath
  ////////////////////////////////////////////////////////////////////////////
  reqAckPort portInst (
    .clk      (clk),
    .rst      (rst),
    .req      (req),
    .cmd      (cmd),
    .respNext (respNext),
    .ack      (ack),
    .cmdReg   (cmdReg),
    .resp     (resp)
  );

  // Both adders run every cycle on the held command
  wordAdder wordInst (
    .a    (cmdReg.a),
    .b    (cmdReg.b),
    .sub  (cmdReg.op[0]),
    .res  (wordRes),
    .ovfl (wordOvfl),
    .neg  ()             // Merge derives the sign from the chosen result
  );

  nibbleAdder nibInst (
    .a    (cmdReg.a),
    .b    (cmdReg.b),
    .sub  (cmdReg.op[0]),
    .res  (nibRes),
    .ovfl (nibOvfl)
  );

  resultMerge mergeInst (
    .nibMode  (cmdReg.op[1]),
    .wordRes  (wordRes),
    .nibRes   (nibRes),
    .wordOvfl (wordOvfl),
    .nibOvfl  (nibOvfl),
    .resp     (respNext)
  );

endmodule

`default_nettype wire

/* dv/clkGen.sv */
`timescale 1ns/10ps
`default_nettype none

module clkGen #(
  parameter int resetCycles = 8     // Rising edges with rst held high
) (
  output logic clk,
  output logic rst
);

  localparam time halfPeriod = 50ns;  // 100 ns clock

  initial begin
    clk = 1'b0;
    forever #(halfPeriod) clk = ~clk;
  end

  // Release on a falling edge, clear of the sampling edge
  initial begin
    rst = 1'b1;
    repeat (resetCycles) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
  end

endmodule

`default_nettype wire

/* dv/aluModel.svh */
`ifndef ALU_MODEL_SVH
`define ALU_MODEL_SVH

// Expected response, worked out from signed arithmetic
function automatic aluRespT predictResp(input aluCmdT c);
  aluRespT            exp;
  logic signed [16:0] wSum;   // One bit wider than the word, never wraps
  logic signed [4:0]  lSum;   // One bit wider than a lane
  logic signed [3:0]  la;
  logic signed [3:0]  lb;
  logic [15:0]        res;
  logic               sat;
  sat = 1'b0;
  if (!c.op[1]) begin
    // Word mode
    if (c.op[0])
      wSum = $signed({c.a[15], c.a}) - $signed({c.b[15], c.b});
    else
      wSum = $signed({c.a[15], c.a}) + $signed({c.b[15], c.b});
    if (wSum > 17'sd32767) begin
      res = 16'h7FFF;
      sat = 1'b1;
    end else if (wSum < -17'sd32768) begin
      res = 16'h8000;
      sat = 1'b1;
    end else begin
      res = wSum[15:0];
    end
  end else begin
    for (int i = 0; i < 4; i++) begin  // Lanes are independent
      la   = c.a[i*4 +: 4];
      lb   = c.b[i*4 +: 4];
      lSum = c.op[0] ? la - lb : la + lb;
      if (lSum > 5'sd7) begin
        res[i*4 +: 4] = 4'h7;
        sat = 1'b1;
      end else if (lSum < -5'sd8) begin
        res[i*4 +: 4] = 4'h8;
        sat = 1'b1;
      end else begin
        res[i*4 +: 4] = lSum[3:0];
      end
    end
  end
  exp.result     = res;
  exp.flags.zero = (res == 16'h0000);
  exp.flags.neg  = res[15];
  exp.flags.ovfl = sat;
  return exp;
endfunction

`endif

/* dv/aluTb.sv */
`timescale 1ns/10ps
`default_nettype none

module aluTb;

  import aluPkg::*;
  `include "aluModel.svh"

  localparam int resetCycles   = 8;
  localparam int numDirected   = 8;
  localparam int numRandom     = 200;
  localparam int cyclesPerCmd  = 10;  // Worst case is about 6
  localparam int timeoutCycles = resetCycles + (numDirected + numRandom) * cyclesPerCmd;
  localparam int ackWaitLimit  = 8;   // Edges to wait for ack before giving up

  logic    clk;
  logic    rst;
  logic    req;
  logic    ack;
  aluCmdT  cmd;
  aluRespT resp;
  int      seed;
  int      cycleCount;
  int      opSeen [4];  // Random commands per opcode

  clkGen #(.resetCycles(resetCycles)) clkGenInst (.clk(clk), .rst(rst));

  aluTop aluTop_inst (
    .clk  (clk),
    .rst  (rst),
    .req  (req),
    .cmd  (cmd),
    .ack  (ack),
    .resp (resp)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Failure handling and compare tasks
  ////////////////////////////////////////////////////////////////////////////
  task automatic stopOnError(input string msg);
    $display("%s", msg);
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic checkResp(input aluRespT exp, input string ctx);
    if (resp !== exp)
      stopOnError($sformatf({"** Error: resp.result = 0x%h expected 0x%h, ",
                             "resp.flags = 0x%h expected 0x%h (%s)"},
                            resp.result, exp.result, resp.flags, exp.flags, ctx));
  endtask

  task automatic checkAck(input logic exp, input string when);
    if (ack !== exp)
      stopOnError($sformatf("Protocol error: ack was %b %s, it should be %b", ack, when, exp));
  endtask

  function automatic aluCmdT makeCmd(input aluOpT op, input logic [15:0] a, input logic [15:0] b);
    aluCmdT c;
    c.op = op;
    c.a  = a;
    c.b  = b;
    return c;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Four-phase driver that starts and ends on a falling edge with ack low
  ////////////////////////////////////////////////////////////////////////////
  task automatic runCmd(input aluCmdT c, input int extraHold);
    aluRespT exp;
    int      edges;
    string   ctx;
    exp   = predictResp(c);
    ctx   = $sformatf("op %s a 0x%h b 0x%h", c.op.name(), c.a, c.b);
    cmd   = c;
    req   = 1'b1;
    edges = 0;
    while (ack !== 1'b1 && edges < ackWaitLimit) begin  // Count edges up to ack
      @(negedge clk);
      edges++;
    end
    if (ack !== 1'b1)
      stopOnError($sformatf("Protocol error: no ack within %0d edges for %s", ackWaitLimit, ctx));
    if (edges != 2)
      stopOnError($sformatf("Protocol error: ack came %0d edges after req, not 2", edges));
    checkResp(exp, ctx);
    repeat (extraHold) begin       // Requester stalls and the result must hold
      @(negedge clk);
      checkAck(1'b1, "while req was still held");
      checkResp(exp, {ctx, ", held"});
    end
    req = 1'b0;
    cmd = makeCmd(aluOpT'(~c.op), ~c.a, ~c.b);  // Scrambled so a late capture shows up
    @(negedge clk);
    checkAck(1'b0, "one edge after req dropped");
  endtask

  // Guard against a hung handshake
  initial begin
    cycleCount = 0;
    forever begin
      @(posedge clk);
      cycleCount++;
      if (cycleCount > timeoutCycles)
        stopOnError($sformatf("Timeout: run still going after %0d cycles", timeoutCycles));
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////
  initial begin
    aluCmdT      c;
    logic [31:0] r;
    seed   = 41;
    req    = 1'b0;
    cmd    = '0;
    opSeen = '{default: 0};
    @(negedge clk);
    while (rst) @(negedge clk);
    repeat (3) begin               // Idle port right after reset
      checkAck(1'b0, "after reset with req low");
      checkResp('0, "after reset");
      @(negedge clk);
    end
    // Directed word cases
    runCmd(makeCmd(opAdd, 16'h7FFF, 16'h0001), 0);
    runCmd(makeCmd(opSub, 16'h8000, 16'h0001), 0);
    runCmd(makeCmd(opSub, 16'h0005, 16'h0005), 0);
    runCmd(makeCmd(opAdd, 16'h1234, 16'h0101), 0);
    // Directed nibble cases lane by lane
    runCmd(makeCmd(opPaddsb, 16'h7777, 16'h1111), 0);
    runCmd(makeCmd(opPsubsb, 16'h8888, 16'h1111), 0);
    runCmd(makeCmd(opPaddsb, 16'h7A35, 16'h1B2C), 0);  // Mixed lanes
    runCmd(makeCmd(opPaddsb, 16'h1234, 16'h2121), 0);  // No lane clamps
    for (int n = 0; n < numRandom; n++) begin
      r    = $random(seed);
      c.op = aluOpT'(r[1:0]);
      c.a  = r[31:16];
      r    = $random(seed);
      c.b  = r[15:0];
      opSeen[int'(c.op)]++;
      runCmd(c, int'(r[17:16]));   // 0 to 3 extra hold cycles
    end
    for (int k = 0; k < 4; k++)
      if (opSeen[k] == 0)
        stopOnError($sformatf("Random stimulus never issued opcode %0d", k));
    $display("PASS: all tests");
    $finish;
  end

endmodule

`default_nettype wire

/* sim.f */
+incdir+dv
hdl/aluPkg.sv
hdl/cla4.sv
hdl/wordAdder.sv
hdl/nibbleAdder.sv
hdl/resultMerge.sv
hdl/reqAckPort.sv
hdl/aluTop.sv
dv/clkGen.sv
dv/aluTb.sv
